//--- fp_pkg.sv
package fp_pkg;

    // binary32 field widths.
    localparam int EXP_W = 8;
    localparam int FRAC_W = 23;
    localparam int WORD_W = 32;

    // exponent of 1.0.
    localparam int EXP_BIAS = 127;

    // operation codes seen on the fp_unit op port.
    typedef enum logic [2:0] {
        FP_ADD  = 3'd0,
        FP_SUB  = 3'd1,
        FP_MUL  = 3'd2,
        FP_ITOF = 3'd3,
        FP_FTOI = 3'd4
    } fp_op_t;

    // execution unit picked by the opcode.
    typedef enum logic [1:0] {
        SEL_ADD = 2'd0,
        SEL_MUL = 2'd1,
        SEL_CVT = 2'd2
    } unit_sel_t;

    // one binary32 word, msb first.
    // a zero exponent always reads as zero, there are no denormals.
    typedef struct packed {
        logic              sign;
        logic [EXP_W-1:0]  exponent;
        logic [FRAC_W-1:0] fraction;
    } fp32_t;

endpackage

//--- fp_issue.sv
`timescale 1ns/1ns

module fp_issue (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  fp_pkg::fp_op_t op,
    output logic           add_start,
    output logic           mul_start,
    output logic           cvt_start,
    output logic           sub,
    input  logic           add_done,
    input  logic           mul_done,
    input  logic           cvt_done,
    input  fp_pkg::fp32_t  add_result,
    input  fp_pkg::fp32_t  mul_result,
    input  fp_pkg::fp32_t  cvt_result,
    output fp_pkg::fp32_t  result,
    output logic           ready
);
    import fp_pkg::*;

    unit_sel_t sel_d;
    unit_sel_t sel_q;
    logic      accept;

    always_comb begin
        case (op)
            FP_MUL:  sel_d = SEL_MUL;
            FP_ITOF: sel_d = SEL_CVT;
            FP_FTOI: sel_d = SEL_CVT;
            default: sel_d = SEL_ADD;
        endcase
    end

    // starts while busy are dropped.
    assign accept = start && ready;

    assign add_start = accept && (sel_d == SEL_ADD);
    assign mul_start = accept && (sel_d == SEL_MUL);
    assign cvt_start = accept && (sel_d == SEL_CVT);
    assign sub = (op == FP_SUB);

    always_ff @(posedge clk) begin
        if (rst) begin
            sel_q <= SEL_ADD;
        end else if (accept) begin
            sel_q <= sel_d;
        end
    end

    // ready and result follow the unit started last.
    always_comb begin
        case (sel_q)
            SEL_MUL: begin
                ready = mul_done;
                result = mul_result;
            end
            SEL_CVT: begin
                ready = cvt_done;
                result = cvt_result;
            end
            default: begin
                ready = add_done;
                result = add_result;
            end
        endcase
    end

    assert property (@(posedge clk) disable iff (rst)
        $onehot0({add_start, mul_start, cvt_start})
        && (!ready -> !(add_start || mul_start || cvt_start)));

    // every unit must drop its done on the cycle after its start.
    assert property (@(posedge clk) disable iff (rst)
        (add_start || mul_start || cvt_start) |=> !ready);

endmodule

//--- fp_add.sv
`timescale 1ns/1ns

module fp_add (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  logic          sub,
    input  fp_pkg::fp32_t a,
    input  fp_pkg::fp32_t b,
    output fp_pkg::fp32_t result,
    output logic          done
);
    import fp_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ALIGN,
        ST_SIGN,
        ST_SUM,
        ST_NORM
    } add_state_t;

    add_state_t        state;
    fp32_t             a_q;
    fp32_t             b_q;
    logic [FRAC_W:0]   sig_a;
    logic [FRAC_W:0]   sig_b;
    logic [FRAC_W+2:0] al_a;
    logic [FRAC_W+2:0] al_b;
    logic [FRAC_W+2:0] sum;
    logic [FRAC_W+1:0] mag;
    logic [EXP_W-1:0]  exp_q;
    logic              sum_sign;
    logic              res_sign;

    assign sig_a = (a_q.exponent == '0) ? '0 : {1'b1, a_q.fraction};
    assign sig_b = (b_q.exponent == '0) ? '0 : {1'b1, b_q.fraction};

    // two's complement sum, msb is the sign.
    assign sum = al_a + al_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        a_q <= a;
                        b_q <= '{sign: b.sign ^ sub, exponent: b.exponent,
                                 fraction: b.fraction};
                        state <= ST_ALIGN;
                    end
                end
                ST_ALIGN: begin
                    // bits shifted out of the smaller one are lost.
                    if (a_q.exponent > b_q.exponent) begin
                        al_a <= (FRAC_W+3)'(sig_a);
                        al_b <= (FRAC_W+3)'(sig_b >> (a_q.exponent - b_q.exponent));
                        exp_q <= a_q.exponent;
                    end else begin
                        al_a <= (FRAC_W+3)'(sig_a >> (b_q.exponent - a_q.exponent));
                        al_b <= (FRAC_W+3)'(sig_b);
                        exp_q <= b_q.exponent;
                    end
                    state <= ST_SIGN;
                end
                ST_SIGN: begin
                    if (a_q.sign == b_q.sign) begin
                        sum_sign <= a_q.sign;
                    end else if (a_q.sign) begin
                        al_a <= al_b;
                        al_b <= -al_a;
                        sum_sign <= 1'b0;
                    end else begin
                        al_b <= -al_b;
                        sum_sign <= 1'b0;
                    end
                    state <= ST_SUM;
                end
                ST_SUM: begin
                    if (sum[FRAC_W+2]) begin
                        res_sign <= 1'b1;
                        mag <= (FRAC_W+2)'(-sum);
                    end else begin
                        res_sign <= sum_sign;
                        mag <= sum[FRAC_W+1:0];
                    end
                    state <= ST_NORM;
                end
                ST_NORM: begin
                    if (mag[FRAC_W+1]) begin
                        // carry out, one step right.
                        mag <= {1'b0, mag[FRAC_W+1:1]};
                        exp_q <= exp_q + 1'b1;
                        state <= ST_IDLE;
                    end else if (!mag[FRAC_W]) begin
                        if (mag == '0) begin
                            res_sign <= 1'b0;
                            exp_q <= '0;
                            state <= ST_IDLE;
                        end else begin
                            mag <= {mag[FRAC_W:0], 1'b0};
                            exp_q <= exp_q - 1'b1;
                        end
                    end else begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign result = {res_sign, exp_q, mag[FRAC_W-1:0]};
    assign done = (state == ST_IDLE);

    // done only comes back out of normalization.
    assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(state) == ST_NORM);

endmodule

//--- fp_mul_iter.sv
`timescale 1ns/1ns

module fp_mul_iter #(
    parameter int BITS_PER_CYCLE = 6
) (
    input  logic                          clk,
    input  logic                          start,
    input  logic [fp_pkg::FRAC_W:0]       a,
    input  logic [fp_pkg::FRAC_W:0]       b,
    output logic [2*fp_pkg::FRAC_W+1:0]   product,
    output logic                          done
);
    import fp_pkg::*;

    localparam int SIG_W = FRAC_W + 1;
    localparam int STEPS = SIG_W / BITS_PER_CYCLE;
    localparam int CNT_W = $clog2(STEPS + 1);

    logic [SIG_W-1:0]   a_q;
    logic [SIG_W-1:0]   b_q;
    logic [2*SIG_W-1:0] acc;
    logic [2*SIG_W-1:0] partial;
    logic [CNT_W-1:0]   count;

    if (SIG_W % BITS_PER_CYCLE != 0) begin : g_bad_step
        $error("BITS_PER_CYCLE must divide %0d", SIG_W);
    end

    // b times the top slice of a.
    assign partial = (2*SIG_W)'(b_q) * (2*SIG_W)'(a_q[SIG_W-1 -: BITS_PER_CYCLE]);

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
            acc <= '0;
            count <= CNT_W'(STEPS);
        end else if (!done) begin
            acc <= (acc << BITS_PER_CYCLE) + partial;
            a_q <= a_q << BITS_PER_CYCLE;
            count <= count - 1'b1;
        end
    end

    assign done = (count == '0);
    assign product = acc;

endmodule

//--- fp_mul.sv
`timescale 1ns/1ns

module fp_mul #(
    parameter int BITS_PER_CYCLE = 6
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          start,
    input  fp_pkg::fp32_t a,
    input  fp_pkg::fp32_t b,
    output fp_pkg::fp32_t result,
    output logic          done
);
    import fp_pkg::*;

    localparam int SIG_W = FRAC_W + 1;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_MULT,
        ST_NORM
    } mul_state_t;

    mul_state_t         state;
    fp32_t              a_q;
    fp32_t              b_q;
    fp32_t              res_q;
    logic               sign_q;
    logic               zero_q;
    logic [EXP_W+1:0]   exp_q;
    logic [SIG_W-1:0]   sig_a;
    logic [SIG_W-1:0]   sig_b;
    logic [2*SIG_W-1:0] product;
    logic               iter_start;
    logic               iter_done;

    assign sig_a = {1'b1, a_q.fraction};
    assign sig_b = {1'b1, b_q.fraction};
    assign iter_start = (state == ST_SETUP);

    fp_mul_iter #(
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) i_iter (
        .clk     (clk),
        .start   (iter_start),
        .a       (sig_a),
        .b       (sig_b),
        .product (product),
        .done    (iter_done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        a_q <= a;
                        b_q <= b;
                        state <= ST_SETUP;
                    end
                end
                ST_SETUP: begin
                    sign_q <= a_q.sign ^ b_q.sign;
                    zero_q <= (a_q.exponent == '0) || (b_q.exponent == '0);
                    exp_q <= (EXP_W+2)'(a_q.exponent) + (EXP_W+2)'(b_q.exponent)
                             - (EXP_W+2)'(EXP_BIAS);
                    state <= ST_MULT;
                end
                ST_MULT: begin
                    if (iter_done) begin
                        state <= ST_NORM;
                    end
                end
                ST_NORM: begin
                    // product is in [1, 4), low bits are dropped.
                    if (zero_q) begin
                        res_q <= '0;
                    end else if (product[2*SIG_W-1]) begin
                        res_q.sign <= sign_q;
                        res_q.exponent <= exp_q[EXP_W-1:0] + 1'b1;
                        res_q.fraction <= product[2*SIG_W-2 -: FRAC_W];
                    end else begin
                        res_q.sign <= sign_q;
                        res_q.exponent <= exp_q[EXP_W-1:0];
                        res_q.fraction <= product[2*SIG_W-3 -: FRAC_W];
                    end
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    assign result = res_q;
    assign done = (state == ST_IDLE);

endmodule

//--- fp_convert.sv
`timescale 1ns/1ns

module fp_convert (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  fp_pkg::fp_op_t op,
    input  fp_pkg::fp32_t  a,
    output fp_pkg::fp32_t  result,
    output logic           done
);
    import fp_pkg::*;

    localparam int LEAD_W = $clog2(WORD_W);

    logic [WORD_W-1:0] a_bits;
    logic [WORD_W-1:0] mag;
    logic [WORD_W-1:0] norm;
    logic [LEAD_W-1:0] lead;
    fp32_t             itof_res;
    logic [WORD_W-1:0] sig_ext;
    logic [WORD_W-1:0] ival;
    logic [EXP_W-1:0]  shift;
    logic [WORD_W-1:0] ftoi_res;
    fp32_t             res_q;

    assign a_bits = a;

    // integer to float.
    always_comb begin
        mag = a_bits[WORD_W-1] ? -a_bits : a_bits;
        lead = '0;
        for (int i = 0; i < WORD_W; i++) begin
            if (mag[i]) begin
                lead = LEAD_W'(i);
            end
        end
        norm = mag << (LEAD_W'(WORD_W - 1) - lead);
        if (mag == '0) begin
            itof_res = '0;
        end else begin
            itof_res.sign = a_bits[WORD_W-1];
            itof_res.exponent = EXP_W'(EXP_BIAS) + EXP_W'(lead);
            itof_res.fraction = norm[WORD_W-2 -: FRAC_W];
        end
    end

    // float to integer, truncated toward zero.
    always_comb begin
        sig_ext = WORD_W'({1'b1, a.fraction});
        shift = a.exponent - EXP_W'(EXP_BIAS);
        if (a.exponent < EXP_W'(EXP_BIAS)) begin
            ival = '0;
        end else if (shift >= EXP_W'(FRAC_W)) begin
            ival = sig_ext << (shift - EXP_W'(FRAC_W));
        end else begin
            ival = sig_ext >> (EXP_W'(FRAC_W) - shift);
        end
        ftoi_res = a.sign ? -ival : ival;
    end

    always_ff @(posedge clk) begin
        if (start) begin
            if (op == FP_ITOF) begin
                res_q <= itof_res;
            end else begin
                res_q <= ftoi_res;
            end
        end
    end

    // low for exactly the cycle after start.
    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b1;
        end else begin
            done <= !start;
        end
    end

    assign result = res_q;

endmodule

//--- fp_unit.sv
`timescale 1ns/1ns

module fp_unit #(
    parameter int BITS_PER_CYCLE = 6
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           start,
    input  fp_pkg::fp_op_t op,
    input  fp_pkg::fp32_t  a,
    input  fp_pkg::fp32_t  b,
    output fp_pkg::fp32_t  result,
    output logic           ready
);
    import fp_pkg::*;

    logic  add_start;
    logic  mul_start;
    logic  cvt_start;
    logic  sub;
    logic  add_done;
    logic  mul_done;
    logic  cvt_done;
    fp32_t add_result;
    fp32_t mul_result;
    fp32_t cvt_result;

    fp_issue i_issue (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .op         (op),
        .add_start  (add_start),
        .mul_start  (mul_start),
        .cvt_start  (cvt_start),
        .sub        (sub),
        .add_done   (add_done),
        .mul_done   (mul_done),
        .cvt_done   (cvt_done),
        .add_result (add_result),
        .mul_result (mul_result),
        .cvt_result (cvt_result),
        .result     (result),
        .ready      (ready)
    );

    fp_add i_add (
        .clk    (clk),
        .rst    (rst),
        .start  (add_start),
        .sub    (sub),
        .a      (a),
        .b      (b),
        .result (add_result),
        .done   (add_done)
    );

    fp_mul #(
        .BITS_PER_CYCLE(BITS_PER_CYCLE)
    ) i_mul (
        .clk    (clk),
        .rst    (rst),
        .start  (mul_start),
        .a      (a),
        .b      (b),
        .result (mul_result),
        .done   (mul_done)
    );

    fp_convert i_cvt (
        .clk    (clk),
        .rst    (rst),
        .start  (cvt_start),
        .op     (op),
        .a      (a),
        .result (cvt_result),
        .done   (cvt_done)
    );

endmodule

//--- tb_fp_unit.sv
`timescale 1ns/1ns

module tb_fp_unit;
    import fp_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam int ROUNDS = 20;

    logic   clk;
    logic   rst;
    logic   start;
    fp_op_t op;
    fp32_t  a;
    fp32_t  b;
    fp32_t  result;
    logic   ready;

    fp32_t  expected;
    logic   busy_model;
    logic   aborted;
    int     seed;
    int     ops_run;
    int     value_errors;
    int     handshake_errors;
    int     timeouts;

    fp_unit #(
        .BITS_PER_CYCLE(6)
    ) i_dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a      (a),
        .b      (b),
        .result (result),
        .ready  (ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // set by an accepted start, cleared once ready is back.
    always @(posedge clk) begin
        if (rst) begin
            busy_model <= 1'b0;
        end else if (start && ready) begin
            busy_model <= 1'b1;
        end else if (ready) begin
            busy_model <= 1'b0;
        end
    end

    assert property (@(posedge clk) $fell(rst) |-> ready)
        else begin
            handshake_errors++;
            $display("ready was low right after reset");
        end

    assert property (@(posedge clk) disable iff (rst) (start && ready) |=> !ready)
        else begin
            handshake_errors++;
            $display("ready stayed high after an accepted start");
        end

    assert property (@(posedge clk) disable iff (rst) (ready && !start) |=> ready)
        else begin
            handshake_errors++;
            $display("ready dropped without an accepted start");
        end

    assert property (@(posedge clk) disable iff (rst) $rose(ready) |-> busy_model)
        else begin
            handshake_errors++;
            $display("ready rose with no operation pending");
        end

    assert property (@(posedge clk) disable iff (rst) $rose(ready) |-> result == expected)
        else begin
            value_errors++;
            $display("error: result = 0x%08h, expected 0x%08h",
                     $sampled(result), $sampled(expected));
        end

    // exact binary32 image of an integer below 2^24 in magnitude.
    function automatic fp32_t to_float(input int v);
        fp32_t f;
        int    m;
        int    e;
        f = '0;
        m = (v < 0) ? -v : v;
        if (m != 0) begin
            e = 0;
            while ((m >> (e + 1)) != 0) begin
                e++;
            end
            f.sign = (v < 0);
            f.exponent = EXP_W'(EXP_BIAS + e);
            f.fraction = FRAC_W'((m << (FRAC_W - e)) - (1 << FRAC_W));
        end
        return f;
    endfunction

    task automatic start_op(input fp_op_t o, input fp32_t x, input fp32_t y,
                            input fp32_t want);
        if (!aborted) begin
            @(posedge clk);
            start <= 1'b1;
            op <= o;
            a <= x;
            b <= y;
            expected <= want;
            ops_run++;
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    task automatic wait_ready(input string what);
        int cycles;
        cycles = 0;
        if (!aborted) begin
            @(negedge clk);
            while (!ready && cycles < TIMEOUT_CYCLES) begin
                @(negedge clk);
                cycles++;
            end
            if (!ready) begin
                timeouts++;
                aborted = 1'b1;
                $display("timeout: the %s operation never raised ready", what);
            end
        end
    endtask

    task automatic run_op(input fp_op_t o, input fp32_t x, input fp32_t y,
                          input fp32_t want, input string what);
        start_op(o, x, y, want);
        wait_ready(what);
    endtask

    // start pulse while a unit is busy, must be dropped.
    task automatic poke_busy(input fp_op_t o, input fp32_t x, input fp32_t y);
        @(posedge clk);
        start <= 1'b1;
        op <= o;
        a <= x;
        b <= y;
        @(posedge clk);
        start <= 1'b0;
    endtask

    initial begin
        int    x;
        int    y;
        int    v;
        fp32_t got;
        seed = 32'h2273;
        ops_run = 0;
        value_errors = 0;
        handshake_errors = 0;
        timeouts = 0;
        aborted = 1'b0;
        rst = 1'b1;
        start = 1'b0;
        op = FP_ADD;
        a = '0;
        b = '0;
        expected = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < ROUNDS; i++) begin
            x = $random(seed) & 32'hfff;
            y = $random(seed) & 32'hfff;
            run_op(FP_ADD, to_float(x), to_float(y), to_float(x + y), "add");
            run_op(FP_SUB, to_float(x), to_float(y), to_float(x - y), "subtract");
            run_op(FP_ADD, to_float(x), to_float(-y), to_float(x - y), "add");
        end
        run_op(FP_SUB, to_float(5), to_float(300), to_float(-295), "subtract");
        run_op(FP_SUB, to_float(1234), to_float(1234), '0, "subtract");
        run_op(FP_ADD, to_float(0), to_float(-77), to_float(-77), "add");

        for (int i = 0; i < ROUNDS; i++) begin
            x = $random(seed) & 32'h7ff;
            y = $random(seed) & 32'h7ff;
            run_op(FP_MUL, to_float(x), to_float(y), to_float(x * y), "multiply");
        end
        run_op(FP_MUL, to_float(-25), to_float(40), to_float(-1000), "multiply");
        run_op(FP_MUL, to_float(0), to_float(77), '0, "multiply");
        run_op(FP_MUL, to_float(-13), to_float(0), '0, "multiply");

        // round trip through both conversions.
        for (int i = 0; i < ROUNDS; i++) begin
            v = $random(seed) % 32'sd16777216;
            run_op(FP_ITOF, fp32_t'(v), '0, to_float(v), "integer to float");
            got = result;
            run_op(FP_FTOI, got, '0, fp32_t'(v), "float to integer");
        end
        run_op(FP_ITOF, '0, '0, '0, "integer to float");

        // 0.5 and -2.75 truncate toward zero.
        run_op(FP_FTOI, '{sign: 1'b0, exponent: 8'd126, fraction: 23'h0}, '0,
               '0, "float to integer");
        run_op(FP_FTOI, '{sign: 1'b1, exponent: 8'd128, fraction: 23'h300000}, '0,
               fp32_t'(-2), "float to integer");

        start_op(FP_MUL, to_float(37), to_float(55), to_float(2035));
        poke_busy(FP_ADD, to_float(1), to_float(2));
        wait_ready("multiply");
        start_op(FP_ADD, to_float(600), to_float(-45), to_float(555));
        poke_busy(FP_ITOF, fp32_t'(99), '0);
        wait_ready("add");
        // idle, so a stray ready rise would show.
        repeat (10) @(posedge clk);

        $display("ops %0d, result errors %0d, handshake errors %0d, timeouts %0d",
                 ops_run, value_errors, handshake_errors, timeouts);
        if (value_errors + handshake_errors + timeouts == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
fp_pkg.sv
fp_issue.sv
fp_add.sv
fp_mul_iter.sv
fp_mul.sv
fp_convert.sv
fp_unit.sv
tb_fp_unit.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the fp_unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_fp_unit -f all.f -o tb_fp_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_fp_unit)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "ALL TESTS PASSED"; then
    exit 0
fi
exit 1
